// ==== sources.f ====
logic/iccm_pkg.sv
logic/iccm_bank_decode.sv
logic/iccm_bank_array.sv
logic/iccm_redundancy.sv
logic/iccm_read_result.sv
logic/iccm_mem.sv
testbench/iccm_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the ICCM testbench

SIM := obj_dir/Viccm_mem_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): sources.f logic/*.sv testbench/iccm_mem_tb.sv
	verilator --binary -Wno-fatal --top-module iccm_mem_tb -Mdir obj_dir -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/iccm_stim.txt ====
# op addr(halfword, bits 9:1) size wr_hi wr_lo exp_rd exp_ecc_hi exp_ecc_lo
# op: W write, C correction pulse, R read, S read with correction state high
W 000 3 02a1a1a1a1 01a0a0a0a0 0000000000000000 0000000000 0000000000
W 004 3 04a3a3a3a3 03a2a2a2a2 0000000000000000 0000000000 0000000000
W 008 3 06a5a5a5a5 05a4a4a4a4 0000000000000000 0000000000 0000000000
W 00c 3 087654abcd 07a6a6a6a6 0000000000000000 0000000000 0000000000
W 010 3 0ab9b9b9b9 091357beef 0000000000000000 0000000000 0000000000
W 000 2 0000000000 1112345678 0000000000000000 0000000000 0000000000
R 000 3 0000000000 0000000000 a1a1a1a112345678 02a1a1a1a1 1112345678
W 004 3 13cafe0001 120badf00d 0000000000000000 0000000000 0000000000
R 004 3 0000000000 0000000000 cafe00010badf00d 13cafe0001 120badf00d
R 005 3 0000000000 0000000000 0000cafe00010bad 13cafe0001 120badf00d
R 00f 3 0000000000 0000000000 00001357beef7654 091357beef 087654abcd
C 008 2 0000000000 14dddd4444 0000000000000000 0000000000 0000000000
R 008 3 0000000000 0000000000 a5a5a5a5dddd4444 06a5a5a5a5 14dddd4444
W 008 2 0000000000 15eeee5555 0000000000000000 0000000000 0000000000
R 008 3 0000000000 0000000000 a5a5a5a5eeee5555 06a5a5a5a5 15eeee5555
C 00c 2 0000000000 16ffff6666 0000000000000000 0000000000 0000000000
R 00c 3 0000000000 0000000000 7654abcdffff6666 087654abcd 16ffff6666
C 004 2 0000000000 1799990000 0000000000000000 0000000000 0000000000
C 010 2 0000000000 1888881111 0000000000000000 0000000000 0000000000
R 00c 3 0000000000 0000000000 7654abcda6a6a6a6 087654abcd 07a6a6a6a6
S 004 3 0000000000 0000000000 cafe000199990000 13cafe0001 1799990000
C 00c 2 0000000000 1977772222 0000000000000000 0000000000 0000000000
R 010 3 0000000000 0000000000 b9b9b9b91357beef 0ab9b9b9b9 091357beef
R 004 3 0000000000 0000000000 cafe000199990000 13cafe0001 1799990000
R 00c 3 0000000000 0000000000 7654abcd77772222 087654abcd 1977772222

// ==== testbench/iccm_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module iccm_mem_tb;

   localparam int CLK_HALF = 20;
   localparam int MAX_OPS  = 64;
   localparam int ROWS     = 2**iccm_pkg::ROW_W;

   logic                    clk;
   logic                    reset;
   logic                    iccm_wren;
   logic                    iccm_rden;
   iccm_pkg::iccm_addr_t    iccm_rw_addr;
   iccm_pkg::iccm_wr_size_e iccm_wr_size;
   iccm_pkg::iccm_wr_data_t iccm_wr_data;
   logic                    iccm_buf_correct_ecc;
   logic                    iccm_correction_state;
   iccm_pkg::iccm_rd_data_t iccm_rd_data;
   iccm_pkg::iccm_wr_data_t iccm_rd_data_ecc;

   // Stimulus table
   logic [7:0]              op_code    [MAX_OPS];
   iccm_pkg::iccm_addr_t    op_addr    [MAX_OPS];
   logic [1:0]              op_size    [MAX_OPS];
   iccm_pkg::iccm_wr_data_t op_wdata   [MAX_OPS];
   iccm_pkg::iccm_rd_data_t op_exp_rd  [MAX_OPS];
   iccm_pkg::iccm_wr_data_t op_exp_ecc [MAX_OPS];
   int                      num_ops;
   logic                    stim_loaded;

   // Reference model
   iccm_pkg::iccm_word_t      model_mem       [iccm_pkg::NUM_BANKS][ROWS];
   iccm_pkg::iccm_word_addr_t model_red_addr  [iccm_pkg::NUM_RED];
   logic                      model_red_valid [iccm_pkg::NUM_RED];
   iccm_pkg::iccm_word_t      model_red_data  [iccm_pkg::NUM_RED];
   logic                      model_lru;

   iccm_mem iccm_mem_inst (
      .clk                   (clk),
      .reset                 (reset),
      .iccm_wren             (iccm_wren),
      .iccm_rden             (iccm_rden),
      .iccm_rw_addr          (iccm_rw_addr),
      .iccm_wr_size          (iccm_wr_size),
      .iccm_wr_data          (iccm_wr_data),
      .iccm_buf_correct_ecc  (iccm_buf_correct_ecc),
      .iccm_correction_state (iccm_correction_state),
      .iccm_rd_data          (iccm_rd_data),
      .iccm_rd_data_ecc      (iccm_rd_data_ecc)
   );

   always #CLK_HALF clk = ~clk;

   //****************************************
   // Reference model
   //****************************************
   function automatic iccm_pkg::iccm_addr_t next_addr(input iccm_pkg::iccm_addr_t addr,
                                                      input logic [1:0] size);
      return addr + ((size == 2'b11) ? 9'd2 : 9'd1);
   endfunction

   // Bank word as seen by a read with spare rows taking precedence
   function automatic iccm_pkg::iccm_word_t model_bank_word(input int bank,
                                                            input iccm_pkg::iccm_addr_t addr,
                                                            input iccm_pkg::iccm_addr_t inc);
      iccm_pkg::iccm_word_t w;
      int                   row;
      row = (int'(addr[4:2]) == bank) ? int'(addr[9:5]) : int'(inc[9:5]);
      w = model_mem[bank][row];
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         if (model_red_valid[r] &&
             ((addr[9:2] == model_red_addr[r] && int'(addr[4:2]) == bank) ||
              (inc[9:2] == model_red_addr[r] && int'(inc[4:2]) == bank))) begin
            w = model_red_data[r];
         end
      end
      return w;
   endfunction

   task automatic model_read(input iccm_pkg::iccm_addr_t addr, input logic [1:0] size,
                             input logic corr_state,
                             output iccm_pkg::iccm_rd_data_t rd,
                             output iccm_pkg::iccm_wr_data_t ecc);
      iccm_pkg::iccm_addr_t    inc;
      iccm_pkg::iccm_word_t    lo;
      iccm_pkg::iccm_word_t    hi;
      iccm_pkg::iccm_rd_data_t pre;
      logic [1:0]              hit;
      inc = next_addr(addr, size);
      lo  = model_bank_word(int'(addr[4:2]), addr, inc);
      hi  = model_bank_word(int'(inc[4:2]), addr, inc);
      pre = {hi[31:0], lo[31:0]};
      rd  = addr[1] ? (pre >> 16) : pre;
      ecc = {hi, lo};
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         hit[r] = model_red_valid[r] &&
                  (addr[9:2] == model_red_addr[r] || inc[9:2] == model_red_addr[r]);
      end
      if (corr_state && hit[0]) begin
         model_lru = 1'b1;
      end else if (corr_state && hit[1]) begin
         model_lru = 1'b0;
      end
   endtask

   task automatic model_write(input iccm_pkg::iccm_addr_t addr, input logic [1:0] size,
                              input iccm_pkg::iccm_wr_data_t wdata);
      iccm_pkg::iccm_addr_t inc;
      logic                 dword;
      inc   = next_addr(addr, size);
      dword = (size == 2'b11);
      for (int b = 0; b < iccm_pkg::NUM_BANKS; b++) begin
         if (int'(addr[4:2]) == b || int'(inc[4:2]) == b) begin
            model_mem[b][int'(addr[9:5])] = (b % 2 == 1) ? wdata[77:39] : wdata[38:0];
         end
      end
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         if (model_red_valid[r] && addr[9:3] == model_red_addr[r][9:3] &&
             (addr[2] == model_red_addr[r][2] || dword)) begin
            model_red_data[r] = (model_red_addr[r][2] && (dword || addr[2])) ?
                                wdata[77:39] : wdata[38:0];
         end
      end
   endtask

   task automatic model_correct(input iccm_pkg::iccm_addr_t addr,
                                input iccm_pkg::iccm_wr_data_t wdata);
      model_red_addr[model_lru]  = addr[9:2];
      model_red_valid[model_lru] = 1'b1;
      model_red_data[model_lru]  = wdata[38:0];
      model_lru = ~model_lru;
   endtask

   //****************************************
   // Failure reporting and compare tasks
   //****************************************
   task automatic stop_on_failure(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_rd_data(input iccm_pkg::iccm_rd_data_t actual,
                                input iccm_pkg::iccm_rd_data_t expected);
      if (actual !== expected) begin
         stop_on_failure($sformatf("ERROR iccm_rd_data got %h expected %h", actual, expected));
      end
   endtask

   task automatic check_rd_ecc(input iccm_pkg::iccm_wr_data_t actual,
                               input iccm_pkg::iccm_wr_data_t expected);
      if (actual !== expected) begin
         stop_on_failure($sformatf("ERROR iccm_rd_data_ecc got %h expected %h",
                                   actual, expected));
      end
   endtask

   //****************************************
   // Stimulus file
   //****************************************
   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  c;
      logic [11:0] a;
      logic [3:0]  s;
      logic [38:0] whi;
      logic [38:0] wlo;
      logic [63:0] erd;
      logic [38:0] ehi;
      logic [38:0] elo;
      fd = $fopen("testbench/iccm_stim.txt", "r");
      if (fd == 0) begin
         stop_on_failure("Could not open the stimulus file testbench/iccm_stim.txt");
      end
      num_ops = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h %h %h %h %h %h", c, a, s, whi, wlo, erd, ehi, elo);
         if (n != 8 || num_ops >= MAX_OPS) begin
            stop_on_failure($sformatf("Stimulus line could not be parsed: %s", line));
         end
         op_code[num_ops]    = c;
         op_addr[num_ops]    = a[8:0];
         op_size[num_ops]    = s[1:0];
         op_wdata[num_ops]   = {whi, wlo};
         op_exp_rd[num_ops]  = erd;
         op_exp_ecc[num_ops] = {ehi, elo};
         num_ops++;
      end
      $fclose(fd);
   endtask

   // Runs the whole table through the model before the DUT sees it
   task automatic cross_check_model();
      iccm_pkg::iccm_rd_data_t rd;
      iccm_pkg::iccm_wr_data_t ecc;
      model_lru = 1'b0;
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         model_red_valid[r] = 1'b0;
      end
      for (int k = 0; k < num_ops; k++) begin
         case (op_code[k])
            "W": model_write(op_addr[k], op_size[k], op_wdata[k]);
            "C": model_correct(op_addr[k], op_wdata[k]);
            "R", "S": begin
               model_read(op_addr[k], op_size[k], op_code[k] == "S", rd, ecc);
               if (rd !== op_exp_rd[k] || ecc !== op_exp_ecc[k]) begin
                  stop_on_failure($sformatf(
                     "Stimulus entry %0d has expected values that the model does not produce", k));
               end
            end
            default: stop_on_failure($sformatf("Unknown opcode in stimulus entry %0d", k));
         endcase
      end
   endtask

   task automatic drive_op(input int k);
      iccm_rw_addr          <= op_addr[k];
      iccm_wr_size          <= iccm_pkg::iccm_wr_size_e'(op_size[k]);
      iccm_wr_data          <= op_wdata[k];
      iccm_wren             <= (op_code[k] == "W");
      iccm_rden             <= (op_code[k] == "R" || op_code[k] == "S");
      iccm_buf_correct_ecc  <= (op_code[k] == "C");
      iccm_correction_state <= (op_code[k] == "S");
   endtask

   task automatic drive_idle();
      iccm_wren             <= 1'b0;
      iccm_rden             <= 1'b0;
      iccm_buf_correct_ecc  <= 1'b0;
      iccm_correction_state <= 1'b0;
   endtask

   //****************************************
   // Main sequence
   //****************************************
   initial begin
      int idle;
      clk                   = 1'b0;
      reset                 = 1'b1;
      iccm_wren             = 1'b0;
      iccm_rden             = 1'b0;
      iccm_rw_addr          = '0;
      iccm_wr_size          = iccm_pkg::SIZE_WORD;
      iccm_wr_data          = '0;
      iccm_buf_correct_ecc  = 1'b0;
      iccm_correction_state = 1'b0;
      stim_loaded           = 1'b0;
      void'($urandom(32'ha059));
      load_stimulus();
      cross_check_model();
      stim_loaded = 1'b1;

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      for (int k = 0; k < num_ops; k++) begin
         idle = int'($urandom % 3);
         repeat (idle) @(posedge clk);
         @(posedge clk);
         drive_op(k);
         @(posedge clk);   // DUT takes the request here
         drive_idle();
         if (op_code[k] == "R" || op_code[k] == "S") begin
            @(negedge clk);
            check_rd_data(iccm_rd_data, op_exp_rd[k]);
            check_rd_ecc(iccm_rd_data_ecc, op_exp_ecc[k]);
         end
      end

      @(posedge clk);
      $display("Testbench passed");
      $finish;
   end

   // Watchdog allows four cycles per entry plus margin
   initial begin
      wait (stim_loaded);
      #(longint'(2*CLK_HALF) * (num_ops + 20) * 4);
      stop_on_failure("Timeout, the stimulus did not complete in the allowed time");
   end

endmodule

`default_nettype wire

// ==== logic/iccm_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module iccm_mem (
   input  logic                    clk,
   input  logic                    reset,

   input  logic                    iccm_wren,
   input  logic                    iccm_rden,
   input  iccm_pkg::iccm_addr_t    iccm_rw_addr,
   input  iccm_pkg::iccm_wr_size_e iccm_wr_size,
   input  iccm_pkg::iccm_wr_data_t iccm_wr_data,
   input  logic                    iccm_buf_correct_ecc,    // Single-cycle correction pulse
   input  logic                    iccm_correction_state,   // High through a correction

   output iccm_pkg::iccm_rd_data_t iccm_rd_data,
   output iccm_pkg::iccm_wr_data_t iccm_rd_data_ecc
);

   iccm_pkg::iccm_addr_t                                  addr_inc;
   iccm_pkg::iccm_bank_req_t [iccm_pkg::NUM_BANKS-1:0]    bank_req;
   iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0]        bank_wr_data;
   iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0]        bank_dout;
   logic [iccm_pkg::NUM_RED-1:0][iccm_pkg::NUM_BANKS-1:0] red_sel_q;
   iccm_pkg::iccm_word_t [iccm_pkg::NUM_RED-1:0]          red_data;

   iccm_bank_decode iccm_bank_decode_inst (
      .iccm_wren    (iccm_wren),
      .iccm_rden    (iccm_rden),
      .iccm_rw_addr (iccm_rw_addr),
      .iccm_wr_size (iccm_wr_size),
      .iccm_wr_data (iccm_wr_data),
      .addr_inc     (addr_inc),
      .bank_req     (bank_req),
      .bank_wr_data (bank_wr_data)
   );

   iccm_bank_array iccm_bank_array_inst (
      .clk          (clk),
      .bank_req     (bank_req),
      .bank_wr_data (bank_wr_data),
      .bank_dout    (bank_dout)
   );

   iccm_redundancy iccm_redundancy_inst (
      .clk                   (clk),
      .reset                 (reset),
      .iccm_wren             (iccm_wren),
      .iccm_rden             (iccm_rden),
      .iccm_buf_correct_ecc  (iccm_buf_correct_ecc),
      .iccm_correction_state (iccm_correction_state),
      .iccm_rw_addr          (iccm_rw_addr),
      .addr_inc              (addr_inc),
      .iccm_wr_size          (iccm_wr_size),
      .iccm_wr_data          (iccm_wr_data),
      .red_sel_q             (red_sel_q),
      .red_data              (red_data)
   );

   iccm_read_result iccm_read_result_inst (
      .clk              (clk),
      .reset            (reset),
      .iccm_rw_addr     (iccm_rw_addr),
      .addr_inc         (addr_inc),
      .bank_dout        (bank_dout),
      .red_sel_q        (red_sel_q),
      .red_data         (red_data),
      .iccm_rd_data     (iccm_rd_data),
      .iccm_rd_data_ecc (iccm_rd_data_ecc)
   );

endmodule

`default_nettype wire

// ==== logic/iccm_read_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module iccm_read_result (
   input  logic                                                  clk,
   input  logic                                                  reset,
   input  iccm_pkg::iccm_addr_t                                  iccm_rw_addr,
   input  iccm_pkg::iccm_addr_t                                  addr_inc,
   input  iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0]        bank_dout,
   input  logic [iccm_pkg::NUM_RED-1:0][iccm_pkg::NUM_BANKS-1:0] red_sel_q,
   input  iccm_pkg::iccm_word_t [iccm_pkg::NUM_RED-1:0]          red_data,

   output iccm_pkg::iccm_rd_data_t                               iccm_rd_data,
   output iccm_pkg::iccm_wr_data_t                               iccm_rd_data_ecc
);

   logic [iccm_pkg::BANK_IDX_W+1:1]                rd_addr_lo_q;   // Low bank and halfword bit
   logic [iccm_pkg::BANK_IDX_W-1:0]                rd_bank_hi_q;
   iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0] bank_fn;
   iccm_pkg::iccm_word_t                           word_lo;
   iccm_pkg::iccm_word_t                           word_hi;
   iccm_pkg::iccm_rd_data_t                        rd_pre;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_addr_lo_q <= '0;
         rd_bank_hi_q <= '0;
      end else begin
         rd_addr_lo_q <= iccm_rw_addr[iccm_pkg::BANK_IDX_W+1:1];
         rd_bank_hi_q <= addr_inc[iccm_pkg::BANK_IDX_W+1:2];
      end
   end

   // Spare row data overrides the bank word
   always_comb begin
      for (int i = 0; i < iccm_pkg::NUM_BANKS; i++) begin
         bank_fn[i] = bank_dout[i];
         for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
            if (red_sel_q[r][i]) begin
               bank_fn[i] = red_data[r];
            end
         end
      end
   end

   //****************************************
   // Alignment
   //****************************************
   assign word_lo = bank_fn[rd_addr_lo_q[iccm_pkg::BANK_IDX_W+1:2]];
   assign word_hi = bank_fn[rd_bank_hi_q];
   assign rd_pre  = {word_hi[iccm_pkg::DATA_W-1:0], word_lo[iccm_pkg::DATA_W-1:0]};

   // Halfword start shifts down, top halfword fills with zero
   assign iccm_rd_data     = rd_addr_lo_q[1] ? (rd_pre >> (iccm_pkg::DATA_W/2)) : rd_pre;
   assign iccm_rd_data_ecc = {word_hi, word_lo};

endmodule

`default_nettype wire

// ==== logic/iccm_redundancy.sv ====
`timescale 1ns/1ps
`default_nettype none

module iccm_redundancy (
   input  logic                                                  clk,
   input  logic                                                  reset,
   input  logic                                                  iccm_wren,
   input  logic                                                  iccm_rden,
   input  logic                                                  iccm_buf_correct_ecc,
   input  logic                                                  iccm_correction_state,
   input  iccm_pkg::iccm_addr_t                                  iccm_rw_addr,
   input  iccm_pkg::iccm_addr_t                                  addr_inc,
   input  iccm_pkg::iccm_wr_size_e                               iccm_wr_size,
   input  iccm_pkg::iccm_wr_data_t                               iccm_wr_data,

   output logic [iccm_pkg::NUM_RED-1:0][iccm_pkg::NUM_BANKS-1:0] red_sel_q,
   output iccm_pkg::iccm_word_t [iccm_pkg::NUM_RED-1:0]          red_data
);

   iccm_pkg::iccm_word_addr_t [iccm_pkg::NUM_RED-1:0]     red_addr;
   logic [iccm_pkg::NUM_RED-1:0]                          red_valid;
   logic                                                  red_lru;   // Spare row to replace next
   logic [iccm_pkg::NUM_RED-1:0][iccm_pkg::NUM_BANKS-1:0] sel;
   logic [iccm_pkg::NUM_RED-1:0]                          addr_en;
   logic [iccm_pkg::NUM_RED-1:0]                          data_en;
   iccm_pkg::iccm_word_t [iccm_pkg::NUM_RED-1:0]          data_in;
   iccm_pkg::iccm_word_addr_t                             rw_word;
   iccm_pkg::iccm_word_addr_t                             inc_word;
   logic                                                  is_dword;
   logic                                                  lru_en;
   logic                                                  lru_in;

   assign rw_word  = iccm_rw_addr[iccm_pkg::ADDR_W:2];
   assign inc_word = addr_inc[iccm_pkg::ADDR_W:2];
   assign is_dword = (iccm_wr_size == iccm_pkg::SIZE_DWORD);

   //****************************************
   // Address match per spare row and bank
   //****************************************
   always_comb begin
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         for (int i = 0; i < iccm_pkg::NUM_BANKS; i++) begin
            sel[r][i] = red_valid[r] &
               (((rw_word == red_addr[r]) &
                 (rw_word[iccm_pkg::BANK_IDX_W+1:2] == iccm_pkg::BANK_IDX_W'(i))) |
                ((inc_word == red_addr[r]) &
                 (inc_word[iccm_pkg::BANK_IDX_W+1:2] == iccm_pkg::BANK_IDX_W'(i))));
         end
      end
   end

   // Correction allocates; read hits under correction steer LRU away from the hit
   assign lru_en = iccm_buf_correct_ecc |
                   ((|sel) & iccm_rden & iccm_correction_state);
   assign lru_in = iccm_buf_correct_ecc ? ~red_lru : (|sel[0]);

   //****************************************
   // Spare row updates
   //****************************************
   always_comb begin
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         addr_en[r] = iccm_buf_correct_ecc & (red_lru == 1'(r));
         // Word writes match through bit 2, doublewords through bit 3
         data_en[r] = addr_en[r] |
                      (iccm_wren & red_valid[r] &
                       (rw_word[iccm_pkg::ADDR_W:3] == red_addr[r][iccm_pkg::ADDR_W:3]) &
                       ((rw_word[2] == red_addr[r][2]) | is_dword));
         if (addr_en[r]) begin
            data_in[r] = iccm_wr_data[iccm_pkg::WORD_W-1:0];   // Correction data is the lower word
         end else if (red_addr[r][2] & (is_dword | rw_word[2])) begin
            data_in[r] = iccm_wr_data[2*iccm_pkg::WORD_W-1:iccm_pkg::WORD_W];
         end else begin
            data_in[r] = iccm_wr_data[iccm_pkg::WORD_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int r = 0; r < iccm_pkg::NUM_RED; r++) begin
         if (addr_en[r]) begin
            red_addr[r] <= rw_word;
         end
         if (data_en[r]) begin
            red_data[r] <= data_in[r];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         red_valid <= '0;
         red_lru   <= 1'b0;
         red_sel_q <= '0;
      end else begin
         red_valid <= red_valid | addr_en;
         if (lru_en) begin
            red_lru <= lru_in;
         end
         red_sel_q <= sel;   // Lines up with the bank read data
      end
   end

endmodule

`default_nettype wire

// ==== logic/iccm_bank_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module iccm_bank_array (
   input  logic                                               clk,
   input  iccm_pkg::iccm_bank_req_t [iccm_pkg::NUM_BANKS-1:0] bank_req,
   input  iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0]     bank_wr_data,

   output iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0]     bank_dout
);

   //****************************************
   // One single-port memory per bank
   //****************************************
   for (genvar i = 0; i < iccm_pkg::NUM_BANKS; i++) begin : g_bank
      iccm_pkg::iccm_word_t mem [0:(2**iccm_pkg::ROW_W)-1];
      iccm_pkg::iccm_word_t dout_q;   // Held while the bank is idle

      always_ff @(posedge clk) begin
         if (bank_req[i].wren) begin
            mem[bank_req[i].row] <= bank_wr_data[i];
         end
         // Old contents on a same-cycle write
         if (bank_req[i].rden) begin
            dout_q <= mem[bank_req[i].row];
         end
      end

      assign bank_dout[i] = dout_q;
   end

endmodule

`default_nettype wire

// ==== logic/iccm_bank_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module iccm_bank_decode (
   input  logic                                             iccm_wren,
   input  logic                                             iccm_rden,
   input  iccm_pkg::iccm_addr_t                             iccm_rw_addr,
   input  iccm_pkg::iccm_wr_size_e                          iccm_wr_size,
   input  iccm_pkg::iccm_wr_data_t                          iccm_wr_data,

   output iccm_pkg::iccm_addr_t                             addr_inc,
   output iccm_pkg::iccm_bank_req_t [iccm_pkg::NUM_BANKS-1:0] bank_req,
   output iccm_pkg::iccm_word_t [iccm_pkg::NUM_BANKS-1:0]   bank_wr_data
);

   logic [iccm_pkg::BANK_IDX_W-1:0] bank_lo;   // Bank of the start address
   logic [iccm_pkg::BANK_IDX_W-1:0] bank_hi;   // Bank of the incremented address
   iccm_pkg::iccm_row_t             row_lo;
   iccm_pkg::iccm_row_t             row_hi;

   // Doubleword steps one full word, anything else one halfword
   assign addr_inc = iccm_rw_addr + ((iccm_wr_size == iccm_pkg::SIZE_DWORD) ?
                                     iccm_pkg::ADDR_W'(2) : iccm_pkg::ADDR_W'(1));

   assign bank_lo = iccm_rw_addr[iccm_pkg::BANK_IDX_W+1:2];
   assign bank_hi = addr_inc[iccm_pkg::BANK_IDX_W+1:2];
   assign row_lo  = iccm_rw_addr[iccm_pkg::ADDR_W:iccm_pkg::BANK_IDX_W+2];
   assign row_hi  = addr_inc[iccm_pkg::ADDR_W:iccm_pkg::BANK_IDX_W+2];

   for (genvar i = 0; i < iccm_pkg::NUM_BANKS; i++) begin : g_bank
      logic hit_lo;
      logic hit_hi;
      logic wr_bank;

      assign hit_lo  = (bank_lo == iccm_pkg::BANK_IDX_W'(i));
      assign hit_hi  = (bank_hi == iccm_pkg::BANK_IDX_W'(i));
      assign wr_bank = iccm_wren & (hit_lo | hit_hi);

      // Row from addr_inc only when this bank was reached through it alone
      assign bank_req[i] = '{
         wren: wr_bank,
         rden: iccm_rden & (hit_lo | hit_hi),
         row:  (!wr_bank && hit_hi && !hit_lo) ? row_hi : row_lo
      };

      // Even banks take the lower word, odd banks the upper
      assign bank_wr_data[i] = iccm_wr_data[(i % 2)*iccm_pkg::WORD_W +: iccm_pkg::WORD_W];
   end

endmodule

`default_nettype wire

// ==== logic/iccm_pkg.sv ====
`default_nettype none

package iccm_pkg;

   //****************************************
   // Geometry
   //****************************************
   localparam int NUM_BANKS  = 8;
   localparam int BANK_IDX_W = 3;    // Bank index is address bits 4:2
   localparam int ROW_W      = 5;    // Row is address bits 9:5, 32 rows per bank
   localparam int ADDR_W     = 9;    // Halfword address, bits 9:1
   localparam int WORD_W     = 39;   // 32 data + 7 check bits
   localparam int DATA_W     = 32;
   localparam int NUM_RED    = 2;    // Spare rows

   //****************************************
   // Address and data types
   //****************************************
   typedef logic [ADDR_W:1]         iccm_addr_t;
   typedef logic [ADDR_W:2]         iccm_word_addr_t;
   typedef logic [ROW_W-1:0]        iccm_row_t;
   typedef logic [WORD_W-1:0]       iccm_word_t;

   // Lower word in the lower half
   typedef logic [2*WORD_W-1:0]     iccm_wr_data_t;
   typedef logic [2*DATA_W-1:0]     iccm_rd_data_t;

   // Write size opcode
   typedef enum logic [1:0] {
      SIZE_WORD  = 2'b10,
      SIZE_DWORD = 2'b11
   } iccm_wr_size_e;

   //****************************************
   // Per-bank request
   //****************************************
   typedef struct packed {
      logic      wren;
      logic      rden;
      iccm_row_t row;
   } iccm_bank_req_t;

endpackage

`default_nettype wire
